/* rtl/isa_pkg.sv */
package isa_pkg;

  typedef logic [31:0] word_t;      // data and address width of the hart
  typedef logic [4:0]  reg_addr_t;  // architectural register index

  // major opcodes this hart executes, anything else decodes as a no-op
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  // funct3 of the register and immediate arithmetic group
  localparam logic [2:0] F3_ADD  = 3'b000;  // add, sub and addi share this code
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;  // srl or sra, picked by instruction bit 30
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct3 of the conditional branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_op_e;

  // source of the value written to rd
  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_PC4,
    WB_IMM
  } wb_sel_e;

  localparam word_t EBREAK_WORD = 32'h0010_0073;
  localparam word_t NOP_WORD    = 32'h0000_0013;  // addi x0, x0, 0

endpackage

/* rtl/pipe_pkg.sv */
package pipe_pkg;

  // fetch to decode, the word is the raw one from instruction memory
  typedef struct packed {
    logic           valid;
    isa_pkg::word_t pc;
    isa_pkg::word_t inst;
  } if_id_t;

  typedef struct packed {
    logic               valid;
    isa_pkg::word_t     pc;
    isa_pkg::word_t     inst;
    isa_pkg::word_t     rs1_data;
    isa_pkg::word_t     rs2_data;
    isa_pkg::word_t     imm;
    isa_pkg::alu_op_e   alu_op;
    logic               op_a_pc;    // first operand is the pc instead of rs1
    logic               op_b_imm;   // second operand is the immediate instead of rs2
    logic               branch;
    logic               jal;
    logic               jalr;
    logic [2:0]         funct3;     // branch condition
    logic               mem_read;
    logic               mem_write;
    isa_pkg::wb_sel_e   wb_sel;
    logic               reg_write;
    isa_pkg::reg_addr_t rd;
    logic               halt;
  } id_ex_t;

  typedef struct packed {
    logic               valid;
    isa_pkg::word_t     pc;
    isa_pkg::word_t     inst;
    isa_pkg::word_t     next_pc;
    isa_pkg::word_t     alu_result;
    isa_pkg::word_t     store_data;
    isa_pkg::word_t     imm;
    logic               mem_read;
    logic               mem_write;
    isa_pkg::wb_sel_e   wb_sel;
    logic               reg_write;
    isa_pkg::reg_addr_t rd;
    logic               halt;
  } ex_mem_t;

  // load data comes straight off the memory port, so nothing is added here
  typedef ex_mem_t mem_wb_t;

  typedef struct packed {
    logic               valid;
    isa_pkg::word_t     inst;
    isa_pkg::word_t     pc;
    isa_pkg::word_t     next_pc;
    isa_pkg::reg_addr_t rd_waddr;
    isa_pkg::word_t     rd_wdata;
    logic               halt;
  } retire_t;

  typedef struct packed {
    isa_pkg::word_t addr;   // always word aligned
    logic           ren;
    logic           wen;
    isa_pkg::word_t wdata;
  } dmem_req_t;

endpackage

/* rtl/stage_reg.sv */
module stage_reg #(
  parameter type payload_t = pipe_pkg::if_id_t
) (
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_en,
  input  logic     i_flush,
  input  payload_t i_d,
  output payload_t o_q
);
  import isa_pkg::*;

  payload_t bubble;

  // every payload has valid and inst, a bubble is an invalid addi x0
  always_comb begin
    bubble      = '0;
    bubble.inst = NOP_WORD;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst || i_flush) begin
      o_q <= bubble;  // flush wins over a held enable
    end else if (i_en) begin
      o_q <= i_d;
    end
  end

endmodule

/* rtl/reg_file.sv */
module reg_file (
  input  logic               i_clk,
  input  logic               i_rst,
  input  isa_pkg::reg_addr_t i_rs1_raddr,
  input  isa_pkg::reg_addr_t i_rs2_raddr,
  input  isa_pkg::reg_addr_t i_rd_waddr,
  input  logic               i_rd_wen,
  input  isa_pkg::word_t     i_rd_wdata,
  output isa_pkg::word_t     o_rs1_rdata,
  output isa_pkg::word_t     o_rs2_rdata
);
  import isa_pkg::*;

  word_t regs [32];  // slot 0 is never written
  logic  wr_live;    // a real write is happening this cycle

  assign wr_live = i_rd_wen && (i_rd_waddr != '0);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[i_rd_waddr] <= i_rd_wdata;
    end
  end

  // x0 reads zero, a read of the register being written sees the new value
  assign o_rs1_rdata = (i_rs1_raddr == '0) ? '0 :
                       (wr_live && i_rd_waddr == i_rs1_raddr) ? i_rd_wdata : regs[i_rs1_raddr];
  assign o_rs2_rdata = (i_rs2_raddr == '0) ? '0 :
                       (wr_live && i_rd_waddr == i_rs2_raddr) ? i_rd_wdata : regs[i_rs2_raddr];

endmodule

/* rtl/fetch_stage.sv */
module fetch_stage #(
  parameter isa_pkg::word_t RESET_ADDR = '0
) (
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic             i_stall,
  input  logic             i_redirect,
  input  isa_pkg::word_t   i_target,
  input  isa_pkg::word_t   i_imem_rdata,
  output isa_pkg::word_t   o_imem_raddr,
  output pipe_pkg::if_id_t o_if_id
);
  import isa_pkg::*;

  word_t pc;       // address of the word arriving on i_imem_rdata this cycle
  word_t next_pc;
  logic  started;  // low for one cycle after reset while the first read is in flight

  // redirect beats stall, a stall or the first cycle re-reads the same word
  always_comb begin
    if (i_redirect) begin
      next_pc = i_target;
    end else if (i_stall || !started) begin
      next_pc = pc;
    end else begin
      next_pc = pc + 32'd4;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc      <= RESET_ADDR;
      started <= 1'b0;
    end else begin
      pc      <= next_pc;
      started <= 1'b1;
    end
  end

  assign o_imem_raddr  = next_pc;  // sync read, the word pairs with pc one edge later
  assign o_if_id.valid = started;
  assign o_if_id.pc    = pc;
  assign o_if_id.inst  = started ? i_imem_rdata : NOP_WORD;  // no stale data before the first read

endmodule

/* rtl/decode_stage.sv */
module decode_stage (
  input  logic               i_clk,
  input  logic               i_rst,
  input  pipe_pkg::if_id_t   i_if_id,
  input  logic               i_wb_en,
  input  isa_pkg::reg_addr_t i_wb_addr,
  input  isa_pkg::word_t     i_wb_data,
  output pipe_pkg::id_ex_t   o_id_ex,
  output isa_pkg::reg_addr_t o_rs1,
  output isa_pkg::reg_addr_t o_rs2
);
  import isa_pkg::*;
  import pipe_pkg::*;

  word_t   inst;
  word_t   imm_i;
  word_t   imm_s;
  word_t   imm_b;
  word_t   imm_u;
  word_t   imm_j;
  word_t   rs1_data;
  word_t   rs2_data;
  alu_op_e arith_op;  // alu function of the op and op-imm groups
  id_ex_t  ctl;       // control and immediate part of the payload
  logic    use_rs1;
  logic    use_rs2;

  assign inst  = i_if_id.inst;
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // formats without a source report x0 so the hazard check stays quiet
  assign o_rs1 = use_rs1 ? inst[19:15] : '0;
  assign o_rs2 = use_rs2 ? inst[24:20] : '0;

  reg_file u_reg_file (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_rs1_raddr (o_rs1),
    .i_rs2_raddr (o_rs2),
    .i_rd_waddr  (i_wb_addr),
    .i_rd_wen    (i_wb_en),
    .i_rd_wdata  (i_wb_data),
    .o_rs1_rdata (rs1_data),
    .o_rs2_rdata (rs2_data)
  );

  // bit 5 of the opcode tells op from op-imm, addi never subtracts
  always_comb begin
    unique case (inst[14:12])
      F3_ADD:  arith_op = (inst[5] && inst[30]) ? ALU_SUB : ALU_ADD;
      F3_SLL:  arith_op = ALU_SLL;
      F3_SLT:  arith_op = ALU_SLT;
      F3_SLTU: arith_op = ALU_SLTU;
      F3_XOR:  arith_op = ALU_XOR;
      F3_SR:   arith_op = inst[30] ? ALU_SRA : ALU_SRL;
      F3_OR:   arith_op = ALU_OR;
      F3_AND:  arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    ctl     = '0;   // unknown opcodes fall through as a no-op
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (opcode_e'(inst[6:0]))
      OP_LUI: begin
        ctl.imm       = imm_u;
        ctl.wb_sel    = WB_IMM;
        ctl.reg_write = 1'b1;
      end
      OP_AUIPC: begin
        ctl.imm       = imm_u;
        ctl.op_a_pc   = 1'b1;  // pc + upper immediate through the adder
        ctl.op_b_imm  = 1'b1;
        ctl.reg_write = 1'b1;
      end
      OP_JAL: begin
        ctl.imm       = imm_j;
        ctl.jal       = 1'b1;
        ctl.wb_sel    = WB_PC4;
        ctl.reg_write = 1'b1;
      end
      OP_JALR: begin
        ctl.imm       = imm_i;
        ctl.jalr      = 1'b1;
        ctl.wb_sel    = WB_PC4;
        ctl.reg_write = 1'b1;
        use_rs1       = 1'b1;
      end
      OP_BRANCH: begin
        ctl.imm    = imm_b;
        ctl.branch = 1'b1;
        use_rs1    = 1'b1;
        use_rs2    = 1'b1;
      end
      OP_LOAD: begin
        ctl.imm       = imm_i;
        ctl.op_b_imm  = 1'b1;  // address is rs1 + offset
        ctl.mem_read  = 1'b1;
        ctl.wb_sel    = WB_MEM;
        ctl.reg_write = 1'b1;
        use_rs1       = 1'b1;
      end
      OP_STORE: begin
        ctl.imm       = imm_s;
        ctl.op_b_imm  = 1'b1;
        ctl.mem_write = 1'b1;
        use_rs1       = 1'b1;
        use_rs2       = 1'b1;
      end
      OP_IMM: begin
        ctl.imm       = imm_i;
        ctl.op_b_imm  = 1'b1;
        ctl.alu_op    = arith_op;
        ctl.reg_write = 1'b1;
        use_rs1       = 1'b1;
      end
      OP_REG: begin
        ctl.alu_op    = arith_op;
        ctl.reg_write = 1'b1;
        use_rs1       = 1'b1;
        use_rs2       = 1'b1;
      end
      default: begin
        // ebreak lands here too, it is flagged as halt below
      end
    endcase
  end

  always_comb begin
    o_id_ex          = ctl;
    o_id_ex.valid    = i_if_id.valid;
    o_id_ex.pc       = i_if_id.pc;
    o_id_ex.inst     = inst;
    o_id_ex.rs1_data = rs1_data;
    o_id_ex.rs2_data = rs2_data;
    o_id_ex.funct3   = inst[14:12];
    o_id_ex.rd       = inst[11:7];
    o_id_ex.halt     = (inst == EBREAK_WORD);
  end

endmodule

/* rtl/hazard_unit.sv */
module hazard_unit (
  input  isa_pkg::reg_addr_t i_rs1,
  input  isa_pkg::reg_addr_t i_rs2,
  input  pipe_pkg::id_ex_t   i_id_ex,
  input  pipe_pkg::ex_mem_t  i_ex_mem,
  output logic               o_stall
);

  logic ex_writes;   // instruction in execute will write a real register
  logic mem_writes;  // same for the one in memory
  logic ex_hit;
  logic mem_hit;

  // mem/wb needs no check, the register file passes its write through
  assign ex_writes  = i_id_ex.valid && i_id_ex.reg_write && (i_id_ex.rd != '0);
  assign mem_writes = i_ex_mem.valid && i_ex_mem.reg_write && (i_ex_mem.rd != '0);

  assign ex_hit  = ex_writes && (i_id_ex.rd == i_rs1 || i_id_ex.rd == i_rs2);
  assign mem_hit = mem_writes && (i_ex_mem.rd == i_rs1 || i_ex_mem.rd == i_rs2);

  assign o_stall = ex_hit || mem_hit;  // at most two cycles per dependency

endmodule

/* rtl/execute_stage.sv */
module execute_stage (
  input  pipe_pkg::id_ex_t  i_id_ex,
  output pipe_pkg::ex_mem_t o_ex_mem,
  output logic              o_redirect,
  output isa_pkg::word_t    o_target
);
  import isa_pkg::*;

  word_t op_a;
  word_t op_b;
  word_t alu_out;
  word_t jalr_sum;
  logic  cond;   // branch condition on rs1 and rs2
  logic  taken;

  assign op_a = i_id_ex.op_a_pc ? i_id_ex.pc : i_id_ex.rs1_data;
  assign op_b = i_id_ex.op_b_imm ? i_id_ex.imm : i_id_ex.rs2_data;

  always_comb begin
    case (i_id_ex.alu_op)
      ALU_SUB:  alu_out = op_a - op_b;
      ALU_AND:  alu_out = op_a & op_b;
      ALU_OR:   alu_out = op_a | op_b;
      ALU_XOR:  alu_out = op_a ^ op_b;
      ALU_SLT:  alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_out = {31'd0, op_a < op_b};
      ALU_SLL:  alu_out = op_a << op_b[4:0];
      ALU_SRL:  alu_out = op_a >> op_b[4:0];
      ALU_SRA:  alu_out = $signed(op_a) >>> op_b[4:0];
      default:  alu_out = op_a + op_b;  // add, also loads, stores and auipc
    endcase
  end

  always_comb begin
    case (i_id_ex.funct3)
      F3_BEQ:  cond = i_id_ex.rs1_data == i_id_ex.rs2_data;
      F3_BNE:  cond = i_id_ex.rs1_data != i_id_ex.rs2_data;
      F3_BLT:  cond = $signed(i_id_ex.rs1_data) < $signed(i_id_ex.rs2_data);
      F3_BGE:  cond = $signed(i_id_ex.rs1_data) >= $signed(i_id_ex.rs2_data);
      F3_BLTU: cond = i_id_ex.rs1_data < i_id_ex.rs2_data;
      F3_BGEU: cond = i_id_ex.rs1_data >= i_id_ex.rs2_data;
      default: cond = 1'b0;
    endcase
  end

  assign taken    = i_id_ex.branch && cond;
  assign jalr_sum = i_id_ex.rs1_data + i_id_ex.imm;

  // jalr drops bit 0 of its sum, branches and jal are pc relative
  assign o_target   = i_id_ex.jalr ? {jalr_sum[31:1], 1'b0} : i_id_ex.pc + i_id_ex.imm;
  assign o_redirect = i_id_ex.valid && (taken || i_id_ex.jal || i_id_ex.jalr);

  always_comb begin
    o_ex_mem.valid      = i_id_ex.valid;
    o_ex_mem.pc         = i_id_ex.pc;
    o_ex_mem.inst       = i_id_ex.inst;
    o_ex_mem.next_pc    = o_redirect ? o_target : i_id_ex.pc + 32'd4;
    o_ex_mem.alu_result = alu_out;
    o_ex_mem.store_data = i_id_ex.rs2_data;
    o_ex_mem.imm        = i_id_ex.imm;
    o_ex_mem.mem_read   = i_id_ex.mem_read;
    o_ex_mem.mem_write  = i_id_ex.mem_write;
    o_ex_mem.wb_sel     = i_id_ex.wb_sel;
    o_ex_mem.reg_write  = i_id_ex.reg_write;
    o_ex_mem.rd         = i_id_ex.rd;
    o_ex_mem.halt       = i_id_ex.halt;
  end

endmodule

/* rtl/writeback_stage.sv */
module writeback_stage (
  input  pipe_pkg::mem_wb_t  i_mem_wb,
  input  isa_pkg::word_t     i_dmem_rdata,
  output logic               o_wb_en,
  output isa_pkg::reg_addr_t o_wb_addr,
  output isa_pkg::word_t     o_wb_data,
  output pipe_pkg::retire_t  o_retire
);
  import isa_pkg::*;

  always_comb begin
    case (i_mem_wb.wb_sel)
      WB_MEM:  o_wb_data = i_dmem_rdata;  // read was issued one edge ago from memory stage
      WB_PC4:  o_wb_data = i_mem_wb.pc + 32'd4;  // link address of jal and jalr
      WB_IMM:  o_wb_data = i_mem_wb.imm;
      default: o_wb_data = i_mem_wb.alu_result;
    endcase
  end

  assign o_wb_en   = i_mem_wb.valid && i_mem_wb.reg_write;
  assign o_wb_addr = o_wb_en ? i_mem_wb.rd : '0;  // stores and branches report x0

  always_comb begin
    o_retire.valid    = i_mem_wb.valid;
    o_retire.inst     = i_mem_wb.inst;
    o_retire.pc       = i_mem_wb.pc;
    o_retire.next_pc  = i_mem_wb.next_pc;
    o_retire.rd_waddr = o_wb_addr;
    o_retire.rd_wdata = o_wb_data;
    o_retire.halt     = i_mem_wb.valid && i_mem_wb.halt;
  end

endmodule

/* rtl/hart.sv */
module hart #(
  parameter isa_pkg::word_t RESET_ADDR = '0
) (
  input  logic                i_clk,
  input  logic                i_rst,
  input  isa_pkg::word_t      i_imem_rdata,
  input  isa_pkg::word_t      i_dmem_rdata,
  output isa_pkg::word_t      o_imem_raddr,
  output pipe_pkg::dmem_req_t o_dmem,
  output pipe_pkg::retire_t   o_retire
);
  import isa_pkg::*;
  import pipe_pkg::*;

  if_id_t    if_id_d;
  if_id_t    if_id_q;
  id_ex_t    id_ex_d;
  id_ex_t    id_ex_q;
  ex_mem_t   ex_mem_d;
  ex_mem_t   ex_mem_q;
  mem_wb_t   mem_wb_q;
  reg_addr_t dec_rs1;
  reg_addr_t dec_rs2;
  logic      stall;
  logic      redirect;
  word_t     target;
  logic      wb_en;
  reg_addr_t wb_addr;
  word_t     wb_data;

  fetch_stage #(
    .RESET_ADDR (RESET_ADDR)
  ) u_fetch (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_stall      (stall),
    .i_redirect   (redirect),
    .i_target     (target),
    .i_imem_rdata (i_imem_rdata),
    .o_imem_raddr (o_imem_raddr),
    .o_if_id      (if_id_d)
  );

  // a stall freezes this register, a redirect kills the wrong-path word
  stage_reg #(.payload_t(if_id_t)) u_if_id (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_en    (!stall),
    .i_flush (redirect),
    .i_d     (if_id_d),
    .o_q     (if_id_q)
  );

  decode_stage u_decode (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_if_id   (if_id_q),
    .i_wb_en   (wb_en),
    .i_wb_addr (wb_addr),
    .i_wb_data (wb_data),
    .o_id_ex   (id_ex_d),
    .o_rs1     (dec_rs1),
    .o_rs2     (dec_rs2)
  );

  hazard_unit u_hazard (
    .i_rs1    (dec_rs1),
    .i_rs2    (dec_rs2),
    .i_id_ex  (id_ex_q),
    .i_ex_mem (ex_mem_q),
    .o_stall  (stall)
  );

  // decode sends a bubble forward while it waits on a producer
  stage_reg #(.payload_t(id_ex_t)) u_id_ex (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_en    (1'b1),
    .i_flush (stall || redirect),
    .i_d     (id_ex_d),
    .o_q     (id_ex_q)
  );

  execute_stage u_execute (
    .i_id_ex    (id_ex_q),
    .o_ex_mem   (ex_mem_d),
    .o_redirect (redirect),
    .o_target   (target)
  );

  stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_en    (1'b1),
    .i_flush (1'b0),
    .i_d     (ex_mem_d),
    .o_q     (ex_mem_q)
  );

  // memory stage is just the port, decode never sets read and write together
  assign o_dmem.addr  = {ex_mem_q.alu_result[31:2], 2'b00};
  assign o_dmem.ren   = ex_mem_q.mem_read;
  assign o_dmem.wen   = ex_mem_q.mem_write;
  assign o_dmem.wdata = ex_mem_q.store_data;

  stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_en    (1'b1),
    .i_flush (1'b0),
    .i_d     (ex_mem_q),
    .o_q     (mem_wb_q)
  );

  writeback_stage u_writeback (
    .i_mem_wb     (mem_wb_q),
    .i_dmem_rdata (i_dmem_rdata),
    .o_wb_en      (wb_en),
    .o_wb_addr    (wb_addr),
    .o_wb_data    (wb_data),
    .o_retire     (o_retire)
  );

endmodule

/* dv/hart_tb.sv */
module hart_tb;
  import isa_pkg::*;
  import pipe_pkg::*;

  localparam word_t RESET_ADDR  = 32'h0000_0000;
  localparam int    MEM_WORDS   = 1024;  // both memories decode address bits 11:2
  localparam int    TESTS_WORDS = 1024;

  logic      clk;
  logic      rst;
  word_t     imem_rdata;
  word_t     dmem_rdata;
  word_t     imem_raddr;
  dmem_req_t dmem_req;
  retire_t   retire;

  word_t   imem [MEM_WORDS];
  word_t   dmem [MEM_WORDS];
  word_t   tests [TESTS_WORDS];  // raw words of the data file, parsed by tag
  retire_t exp_q [$];            // expected retire records in program order

  logic done = 1'b0;             // set once the halt retires or the sequence runs out
  int   retired = 0;
  int   value_errors = 0;
  int   seq_errors = 0;
  int   limit_cycles = 0;

  hart #(
    .RESET_ADDR (RESET_ADDR)
  ) UUT (
    .i_clk        (clk),
    .i_rst        (rst),
    .i_imem_rdata (imem_rdata),
    .i_dmem_rdata (dmem_rdata),
    .o_imem_raddr (imem_raddr),
    .o_dmem       (dmem_req),
    .o_retire     (retire)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // synchronous read, the word shows up one edge after its address
  always @(posedge clk) begin
    imem_rdata <= imem[imem_raddr[11:2]];
  end

  always @(posedge clk) begin
    if (dmem_req.wen) begin
      dmem[dmem_req.addr[11:2]] <= dmem_req.wdata;  // visible to a read from the next edge on
    end
    if (dmem_req.ren) begin
      dmem_rdata <= dmem[dmem_req.addr[11:2]];
    end
  end

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_reg(input string what, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %0t %s: got x%0d, expected x%0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %0t %s: got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic load_tests();
    logic [9:0] idx;
    logic       scanning;
    retire_t    rec;
    $readmemh("dv/hart_tests.txt", tests);
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i[9:0]] = {i[19:0], 5'd31, 7'b0110111};  // lui x31 with the index, flags stray fetches
      dmem[i[9:0]] <= 32'h5a5a_0000 | {20'd0, i[9:0], 2'b00};
    end
    idx      = '0;
    scanning = 1'b1;
    while (scanning) begin
      case (tests[idx])
        32'd1: begin
          imem[tests[idx + 10'd1][11:2]] = tests[idx + 10'd2];
          idx = idx + 10'd3;
        end
        32'd2: begin
          dmem[tests[idx + 10'd1][11:2]] <= tests[idx + 10'd2];  // lands after the fill above
          idx = idx + 10'd3;
        end
        32'd3: begin
          rec          = '0;
          rec.valid    = 1'b1;
          rec.pc       = tests[idx + 10'd1];
          rec.next_pc  = tests[idx + 10'd2];
          rec.rd_waddr = tests[idx + 10'd3][4:0];
          rec.rd_wdata = tests[idx + 10'd4];
          rec.halt     = tests[idx + 10'd5][0];
          exp_q.push_back(rec);
          idx = idx + 10'd6;
        end
        default: scanning = 1'b0;  // end tag, or nothing more was read
      endcase
      if (idx > 10'd1000) begin
        scanning = 1'b0;
      end
    end
  endtask

  task automatic check_retire(input retire_t got);
    retire_t exp;
    if (exp_q.size() == 0) begin
      seq_errors++;
      $display("extra retire of pc %h after the expected sequence ended", got.pc);
      done = 1'b1;
    end else begin
      exp = exp_q.pop_front();
      retired++;
      check_word($sformatf("pc %h pc", exp.pc), got.pc, exp.pc);
      // the retired word must be the one the program placed at this pc
      check_word($sformatf("pc %h inst", exp.pc), got.inst, imem[exp.pc[11:2]]);
      check_word($sformatf("pc %h next pc", exp.pc), got.next_pc, exp.next_pc);
      check_reg($sformatf("pc %h rd", exp.pc), got.rd_waddr, exp.rd_waddr);
      if (exp.rd_waddr != '0) begin
        check_word($sformatf("pc %h rd data", exp.pc), got.rd_wdata, exp.rd_wdata);
      end
      check_flag($sformatf("pc %h halt", exp.pc), got.halt, exp.halt);
      if (got.halt || exp.halt) begin
        if (exp_q.size() != 0) begin
          seq_errors += exp_q.size();
          $display("halt retired with %0d expected retires still missing", exp_q.size());
        end
        done = 1'b1;
      end
    end
  endtask

  // retire comes straight off the mem/wb register, so the falling edge sees it settled
  always @(negedge clk) begin
    if (rst) begin
      if (retire.valid) begin
        seq_errors++;
        $display("retire reported at time %0t while reset is asserted", $time);
      end
    end else if (!done && retire.valid) begin
      check_retire(retire);
    end
  end

  initial begin : watchdog
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: the halt did not retire within %0d cycles", limit_cycles);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    rst        <= 1'b1;
    imem_rdata <= '0;
    dmem_rdata <= '0;
    load_tests();
    limit_cycles = 20 * exp_q.size() + 200;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    wait (done);
    repeat (2) @(posedge clk);
    $display("retires checked: %0d, value errors: %0d, sequence errors: %0d",
             retired, value_errors, seq_errors);
    if (value_errors == 0 && seq_errors == 0 && retired > 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* src.f */
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/stage_reg.sv
rtl/reg_file.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/writeback_stage.sv
rtl/hart.sv
dv/hart_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= hart_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q -F "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/hart_tests.txt */
// tag 1 program: address, instruction   tag 2 data: address, value
// tag 3 expected retire: pc, next pc, rd, rd data, halt   tag 0 ends the list
1 00000000 00500093
1 00000004 ffd00113
1 00000008 402081b3
1 0000000c 40115233
1 00000010 0020b2b3
1 00000014 00419313
1 00000018 01c15393
1 0000001c 00734433
1 00000020 000014b7
1 00000024 0084a023
1 00000028 0004a503
1 0000002c 0044a583
1 00000030 00750013
1 00000034 00b00633
1 00000038 00308463
1 0000003c 00108463
1 00000044 00109463
1 00000048 00309463
1 00000050 0020c463
1 00000054 00114463
1 0000005c 00115463
1 00000060 0020d463
1 00000068 00116463
1 0000006c 0020e463
1 00000074 0020f463
1 00000078 00117463
1 00000080 00c006ef
1 0000008c 00002717
1 00000090 0a100793
1 00000094 00078867
1 000000a0 00100073
2 00001004 12345678
3 00000000 00000004 01 00000005 0
3 00000004 00000008 02 fffffffd 0
3 00000008 0000000c 03 00000008 0
3 0000000c 00000010 04 ffffffff 0
3 00000010 00000014 05 00000001 0
3 00000014 00000018 06 00000080 0
3 00000018 0000001c 07 0000000f 0
3 0000001c 00000020 08 0000008f 0
3 00000020 00000024 09 00001000 0
3 00000024 00000028 00 00000000 0
3 00000028 0000002c 0a 0000008f 0
3 0000002c 00000030 0b 12345678 0
3 00000030 00000034 00 00000000 0
3 00000034 00000038 0c 12345678 0
3 00000038 0000003c 00 00000000 0
3 0000003c 00000044 00 00000000 0
3 00000044 00000048 00 00000000 0
3 00000048 00000050 00 00000000 0
3 00000050 00000054 00 00000000 0
3 00000054 0000005c 00 00000000 0
3 0000005c 00000060 00 00000000 0
3 00000060 00000068 00 00000000 0
3 00000068 0000006c 00 00000000 0
3 0000006c 00000074 00 00000000 0
3 00000074 00000078 00 00000000 0
3 00000078 00000080 00 00000000 0
3 00000080 0000008c 0d 00000084 0
3 0000008c 00000090 0e 0000208c 0
3 00000090 00000094 0f 000000a1 0
3 00000094 000000a0 10 00000098 0
3 000000a0 000000a4 00 00000000 1
0
